// ==== verilog/dma_pkg.sv ====
/*
 * Shared types for the packet read path of the DMA engine.
 * NUM_QUEUES must stay a power of two that matches queue_idx_t,
 * because the arbiter wraps its search by truncation.
 * word_cnt_t holds up to 1023 words, so packets stay below 4 KB.
 */
package dma_pkg;

   // ============================
   // Sizes
   // ============================
   localparam int NUM_QUEUES = 4;         // Network packet queues

   typedef logic [1:0]  queue_idx_t;      // Queue number
   typedef logic [31:0] data_word_t;      // Payload and bus data word
   typedef logic [31:0] host_addr_t;      // Host byte address, +4 per word
   typedef logic [15:0] pkt_len_t;        // Packet length in bytes
   typedef logic [9:0]  word_cnt_t;       // Payload words still to move

   // ============================
   // Structs
   // ============================

   // One FIFO entry
   typedef struct packed {
      data_word_t data;                   // Payload word
      logic       last;                   // Final word of the packet
   } fifo_word_t;

   // Wishbone classic master outputs, write only
   typedef struct packed {
      logic       cyc;                    // Bus cycle in progress
      logic       stb;                    // Valid transfer
      host_addr_t adr;                    // Byte address
      data_word_t dat;                    // Write data
   } wb_m2s_t;

   // ============================
   // Producer FSM
   // ============================
   typedef enum logic [1:0] {
      IDLE,                               // Waiting for rd_start
      GET_LEN,                            // Waiting for the length word
      MOVE,                               // Copying payload into the FIFO
      WAIT_DONE                           // Host writer still draining
   } reader_state_t;

endpackage

// ==== verilog/dma_rr_arb.sv ====
/*
 * Round-robin choice of the next queue with a packet available.
 * grant_q and grant_vld are combinational from pkt_avail and the pointer.
 * The search wraps by truncation, so NUM_QUEUES must be a power of two.
 */
`timescale 1ns/1ps

module dma_rr_arb (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [dma_pkg::NUM_QUEUES-1:0] pkt_avail,  // One bit per queue
   input  logic                           arb_next,   // Grant taken
   output dma_pkg::queue_idx_t            grant_q,    // Queue to serve
   output logic                           grant_vld   // Some queue is ready
);
   import dma_pkg::*;

   queue_idx_t ptr_q;                     // Highest priority queue

   // ============================
   // Search from the pointer
   // ============================
   always_comb
   begin : search
      queue_idx_t idx;
      grant_q   = ptr_q;
      grant_vld = 1'b0;
      // Walk backwards so the nearest busy queue wins last
      for (int i = NUM_QUEUES - 1; i >= 0; i--)
      begin
         idx = queue_idx_t'(ptr_q + i);   // Wraps modulo NUM_QUEUES
         if (pkt_avail[idx])
         begin
            grant_q   = idx;
            grant_vld = 1'b1;
         end
      end
   end

   // ============================
   // Pointer update
   // ============================
   always_ff @(posedge clk)
   begin
      if (reset)
         ptr_q <= '0;                     // Queue 0 first after reset
      else if (arb_next)
         ptr_q <= grant_q + 1'b1;         // Step past the served queue
   end

endmodule

// ==== verilog/dma_cnet_reader.sv ====
/*
 * Producer side of the read path.
 * Requests the granted queue, checks the length word and copies the
 * payload into the FIFO, tagging the final word as last.
 * Lengths of 0 or above MAX_PKT_BYTES are rejected with rd_size_err.
 * MAX_PKT_BYTES must fit the word counter, so 4092 at most.
 * The state holds in WAIT_DONE until the host writer reports xfer_done.
 */
`timescale 1ns/1ps

module dma_cnet_reader #(
   parameter int MAX_PKT_BYTES = 2048
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           rd_start,       // Host start pulse
   input  logic [dma_pkg::NUM_QUEUES-1:0] pkt_avail,
   input  dma_pkg::data_word_t            data_frm_cnet,  // Show-ahead head word
   input  logic                           cnet_empty,
   input  logic                           fifo_full,
   input  logic                           xfer_done,      // Writer finished packet
   output logic                           rd_request,
   output dma_pkg::queue_idx_t            rd_request_q,
   output logic                           rd_en,          // Pop from source
   output dma_pkg::queue_idx_t            rd_mac,         // Queue served
   output dma_pkg::pkt_len_t              rd_size,        // Packet bytes
   output logic                           rd_size_err,
   output logic                           rd_in_progress,
   output logic                           fifo_push,
   output dma_pkg::fifo_word_t            fifo_din
);
   import dma_pkg::*;

   reader_state_t state_q;
   queue_idx_t    grant_q;
   logic          grant_vld;
   logic          arb_next;
   queue_idx_t    cur_q;                  // Queue latched at start
   word_cnt_t     words_left;             // Payload words still to copy
   pkt_len_t      len;                    // Length field of the head word
   logic          len_bad;
   logic          start_ok;
   logic          move_ok;

   dma_rr_arb u_rr_arb (
      .clk       (clk),
      .reset     (reset),
      .pkt_avail (pkt_avail),
      .arb_next  (arb_next),
      .grant_q   (grant_q),
      .grant_vld (grant_vld)
   );

   // ============================
   // Handshakes
   // ============================
   assign start_ok     = rd_start && (state_q == IDLE) && grant_vld;  // No queue, no start
   assign rd_request   = start_ok;
   assign rd_request_q = grant_q;
   assign arb_next     = start_ok;        // Pointer moves with the request

   assign len     = data_frm_cnet[15:0];  // Upper bits carry no size
   assign len_bad = (len == '0) || (len > MAX_PKT_BYTES);

   assign move_ok   = (state_q == MOVE) && !cnet_empty && !fifo_full;
   assign rd_en     = ((state_q == GET_LEN) && !cnet_empty) || move_ok;
   assign fifo_push = move_ok;
   assign fifo_din  = '{data: data_frm_cnet, last: (words_left == word_cnt_t'(1))};

   assign rd_in_progress = (state_q != IDLE);

   // ============================
   // FSM
   // ============================
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q     <= IDLE;
         rd_size_err <= 1'b0;
         rd_size     <= '0;
         rd_mac      <= '0;
      end
      else
      begin
         rd_size_err <= 1'b0;             // Pulse by default
         case (state_q)
            IDLE:
               if (start_ok)
                  state_q <= GET_LEN;
            GET_LEN:
               if (!cnet_empty)
               begin
                  if (len_bad)
                  begin
                     rd_size_err <= 1'b1;
                     state_q     <= IDLE;
                  end
                  else
                  begin
                     rd_size <= len;
                     rd_mac  <= cur_q;
                     state_q <= MOVE;
                  end
               end
            MOVE:
               if (move_ok && (words_left == word_cnt_t'(1)))
                  state_q <= WAIT_DONE;   // Last word just went in
            WAIT_DONE:
               if (xfer_done)
                  state_q <= IDLE;
            default:
               state_q <= IDLE;
         endcase
      end
   end

   // Queue and word count, loaded before use
   always_ff @(posedge clk)
   begin
      if (start_ok)
         cur_q <= grant_q;
      if ((state_q == GET_LEN) && !cnet_empty)
         words_left <= word_cnt_t'(({1'b0, len} + 17'd3) >> 2);  // Round up to words
      else if (move_ok)
         words_left <= words_left - 1'b1;
   end

endmodule

// ==== verilog/dma_read_fifo.sv ====
/*
 * Show-ahead FIFO of payload words with a last flag.
 * fifo_dout is valid whenever fifo_empty is low.
 * A push while full or a pop while empty is ignored.
 * FIFO_DEPTH must be a power of two, at least 2.
 */
`timescale 1ns/1ps

module dma_read_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                fifo_push,
   input  dma_pkg::fifo_word_t fifo_din,
   input  logic                fifo_pop,
   output dma_pkg::fifo_word_t fifo_dout,   // Head entry
   output logic                fifo_full,
   output logic                fifo_empty
);
   import dma_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   fifo_word_t       mem [FIFO_DEPTH];      // Storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;                 // Entries held
   logic             do_push;
   logic             do_pop;

   assign do_push = fifo_push && !fifo_full;
   assign do_pop  = fifo_pop && !fifo_empty;

   assign fifo_full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign fifo_empty = (count == '0);
   assign fifo_dout  = mem[rd_ptr];         // Show-ahead read

   // ============================
   // Pointers and count
   // ============================
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;          // Both at once leaves it alone
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= fifo_din;
   end

endmodule

// ==== verilog/dma_host_writer.sv ====
/*
 * Consumer side of the read path.
 * Wishbone classic master that writes one FIFO word per bus cycle,
 * always a full 32-bit write, never back to back.
 * The first word of a packet goes to rd_addr, the rest follow at +4.
 * rd_addr must be stable from start until done.
 */
`timescale 1ns/1ps

module dma_host_writer (
   input  logic                clk,
   input  logic                reset,
   input  dma_pkg::host_addr_t rd_addr,    // Base for each packet
   input  dma_pkg::fifo_word_t fifo_dout,
   input  logic                fifo_empty,
   input  logic                wb_ack,
   output dma_pkg::wb_m2s_t    wb,
   output logic                fifo_pop,
   output logic                xfer_done   // Packet fully written
);
   import dma_pkg::*;

   logic       cyc_q;                      // cyc and stb together
   host_addr_t adr_q;
   data_word_t dat_q;
   logic       last_q;                     // Word on the bus is the last one
   logic       first_q;                    // Next word starts a packet
   host_addr_t addr_ptr;                   // Next address inside a packet
   host_addr_t next_adr;
   logic       start;
   logic       ack;

   // ============================
   // Bus outputs
   // ============================
   assign wb = '{cyc: cyc_q, stb: cyc_q, adr: adr_q, dat: dat_q};

   assign start    = !cyc_q && !fifo_empty;          // Idle bus and data ready
   assign ack      = cyc_q && wb_ack;
   assign fifo_pop = ack;                            // Word leaves on acknowledge
   assign next_adr = first_q ? rd_addr : addr_ptr;

   // ============================
   // Control
   // ============================
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cyc_q     <= 1'b0;
         first_q   <= 1'b1;                          // Load rd_addr on first word
         xfer_done <= 1'b0;
      end
      else
      begin
         xfer_done <= ack && last_q;                 // One cycle after last ack
         if (ack)
         begin
            cyc_q   <= 1'b0;                         // Drop cyc and stb
            first_q <= last_q;                       // Reload base after last word
         end
         else if (start)
            cyc_q <= 1'b1;
      end
   end

   // ============================
   // Payload
   // ============================
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         adr_q  <= next_adr;
         dat_q  <= fifo_dout.data;
         last_q <= fifo_dout.last;
      end
      if (ack)
         addr_ptr <= adr_q + 32'd4;                  // Next word address
   end

endmodule

// ==== verilog/dma_engine.sv ====
/*
 * Top level of the DMA packet read path.
 * Network queue source -> reader -> FIFO -> Wishbone host writer.
 * The host gives rd_start with rd_addr held until rd_done.
 * A start with no queue available is ignored.
 */
`timescale 1ns/1ps

module dma_engine #(
   parameter int FIFO_DEPTH    = 4,        // Power of two, at least 2
   parameter int MAX_PKT_BYTES = 2048      // Largest legal packet
) (
   input  logic                           clk,
   input  logic                           reset,
   // Host control
   input  logic                           rd_start,
   input  dma_pkg::host_addr_t            rd_addr,
   output logic                           rd_done,
   output logic                           rd_size_err,
   output dma_pkg::queue_idx_t            rd_mac,
   output dma_pkg::pkt_len_t              rd_size,
   output logic                           rd_in_progress,
   // Packet source
   input  logic [dma_pkg::NUM_QUEUES-1:0] pkt_avail,
   output logic                           rd_request,
   output dma_pkg::queue_idx_t            rd_request_q,
   input  dma_pkg::data_word_t            data_frm_cnet,
   input  logic                           cnet_empty,
   output logic                           rd_en,
   // Host bus
   output dma_pkg::wb_m2s_t               wb,
   input  logic                           wb_ack
);
   import dma_pkg::*;

   logic       fifo_push;
   fifo_word_t fifo_din;
   logic       fifo_pop;
   fifo_word_t fifo_dout;
   logic       fifo_full;
   logic       fifo_empty;

   // ============================
   // Producer
   // ============================
   dma_cnet_reader #(
      .MAX_PKT_BYTES (MAX_PKT_BYTES)
   ) u_cnet_reader (
      .clk            (clk),
      .reset          (reset),
      .rd_start       (rd_start),
      .pkt_avail      (pkt_avail),
      .data_frm_cnet  (data_frm_cnet),
      .cnet_empty     (cnet_empty),
      .fifo_full      (fifo_full),
      .xfer_done      (rd_done),           // Writer completion frees the reader
      .rd_request     (rd_request),
      .rd_request_q   (rd_request_q),
      .rd_en          (rd_en),
      .rd_mac         (rd_mac),
      .rd_size        (rd_size),
      .rd_size_err    (rd_size_err),
      .rd_in_progress (rd_in_progress),
      .fifo_push      (fifo_push),
      .fifo_din       (fifo_din)
   );

   // ============================
   // Buffer
   // ============================
   dma_read_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_read_fifo (
      .clk        (clk),
      .reset      (reset),
      .fifo_push  (fifo_push),
      .fifo_din   (fifo_din),
      .fifo_pop   (fifo_pop),
      .fifo_dout  (fifo_dout),
      .fifo_full  (fifo_full),
      .fifo_empty (fifo_empty)
   );

   // ============================
   // Consumer
   // ============================
   dma_host_writer u_host_writer (
      .clk        (clk),
      .reset      (reset),
      .rd_addr    (rd_addr),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty),
      .wb_ack     (wb_ack),
      .wb         (wb),
      .fifo_pop   (fifo_pop),
      .xfer_done  (rd_done)               // Same pulse reaches the host
   );

endmodule

// ==== bench/dma_bench_models.sv ====
/*
 * Bench models around the DMA engine.
 * dma_pkt_source keeps up to 16 packets and 4096 words per queue and
 * inserts random empty cycles. dma_host_mem is a Wishbone classic slave
 * with ack delays of 0 to 3 cycles. All model outputs change 1 ns after
 * the rising clock edge.
 */
`timescale 1ns/1ps

module dma_pkt_source (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           rd_request,
   input  dma_pkg::queue_idx_t            rd_request_q,
   input  logic                           rd_en,
   output logic [dma_pkg::NUM_QUEUES-1:0] pkt_avail,
   output dma_pkg::data_word_t            data_frm_cnet,  // Show-ahead head word
   output logic                           cnet_empty
);
   import dma_pkg::*;

   data_word_t words  [NUM_QUEUES][4096];   // Word store per queue
   int         w_wr   [NUM_QUEUES];
   int         w_rd   [NUM_QUEUES];
   int         pk_len [NUM_QUEUES][16];     // Words per packet, length word included
   int         pk_wr  [NUM_QUEUES];
   int         pk_rd  [NUM_QUEUES];
   int         cur_q;                       // Queue being presented
   int         left;                        // Words left in the open packet

   task automatic add_word(input int q, input data_word_t w);
      words[q][w_wr[q]] = w;
      w_wr[q]++;
   endtask

   task automatic close_packet(input int q, input int n);
      pk_len[q][pk_wr[q]] = n;
      pk_wr[q]++;
   endtask

   initial
   begin
      pkt_avail     = '0;
      data_frm_cnet = '0;
      cnet_empty    = 1'b1;
   end

   always @(posedge clk)
   begin
      if (reset)
         left = 0;
      else if (rd_en && !cnet_empty)
      begin
         w_rd[cur_q]++;                     // Head word consumed
         left--;
      end
      else if (rd_request)
      begin
         cur_q = int'(rd_request_q);
         left  = pk_len[cur_q][pk_rd[cur_q]];
         pk_rd[cur_q]++;                    // Packet leaves the avail list
      end
      #1;
      for (int i = 0; i < NUM_QUEUES; i++)
         pkt_avail[i] = (pk_rd[i] != pk_wr[i]);
      cnet_empty    = (left == 0) || ($urandom_range(3, 0) == 0);  // Random gap
      data_frm_cnet = words[cur_q][w_rd[cur_q]];
   end

endmodule

module dma_host_mem (
   input  logic             clk,
   input  logic             reset,
   input  dma_pkg::wb_m2s_t wb,
   output logic             wb_ack
);
   import dma_pkg::*;

   data_word_t mem [host_addr_t];           // Written words by byte address
   int         n_writes;                    // Completed bus writes
   int         stall;                       // Wait cycles before the next ack

   function automatic data_word_t peek(input host_addr_t adr);
      data_word_t w;
      if (mem.exists(adr))
         w = mem[adr];
      else
         w = 'x;                            // Never written
      return w;
   endfunction

   initial
   begin
      wb_ack   = 1'b0;
      n_writes = 0;
      stall    = 0;
   end

   always @(posedge clk)
   begin
      if (!reset && wb.cyc && wb.stb && wb_ack)
      begin
         mem[wb.adr] = wb.dat;              // Write completes on this edge
         n_writes++;
      end
      #1;
      if (reset || wb_ack || !wb.cyc)
      begin
         wb_ack = 1'b0;
         stall  = $urandom_range(3, 0);
      end
      else if (stall > 0)
         stall--;
      else
         wb_ack = 1'b1;
   end

endmodule

// ==== bench/dma_engine_tb.sv ====
/*
 * Testbench for the DMA engine read path.
 * Packets are loaded into the queue model while the engine is idle and
 * served one rd_start at a time. Each transfer gets its own 4 KB window
 * of host memory, so stale words cannot hide a missing write.
 * The first mismatch ends the run.
 */
`timescale 1ns/1ps

module dma_engine_tb;
   import dma_pkg::*;

   localparam int CLK_PERIOD    = 4;               // ns
   localparam int MAX_PKT_BYTES = 2048;
   localparam int N_PKTS        = 17;              // One single packet, four per queue
   localparam int SEED          = 35;
   localparam int WATCHDOG_CYC  = 2000 * N_PKTS;

   typedef struct packed {
      queue_idx_t  q;                              // Granted queue
      pkt_len_t    size;
      logic        err;                            // Length rejected
      logic [10:0] nwords;                         // Bus writes expected
   } expect_t;

   logic                  clk;
   logic                  reset;
   logic                  rd_start;
   host_addr_t            rd_addr;
   logic                  rd_done;
   logic                  rd_size_err;
   queue_idx_t            rd_mac;
   pkt_len_t              rd_size;
   logic                  rd_in_progress;
   logic [NUM_QUEUES-1:0] pkt_avail;
   logic                  rd_request;
   queue_idx_t            rd_request_q;
   data_word_t            data_frm_cnet;
   logic                  cnet_empty;
   logic                  rd_en;
   wb_m2s_t               wb;
   logic                  wb_ack;

   data_word_t  src_word [NUM_QUEUES][5][513];     // Bench copy of every packet
   int          src_cnt  [NUM_QUEUES];
   int          src_head [NUM_QUEUES];             // Next packet the engine should take
   queue_idx_t  ref_ptr;                           // Expected arbiter pointer
   expect_t     exp_cur;
   int          exp_head;
   logic        busy;                              // A transfer was started
   int          ev_cnt;                            // Done and error events seen
   int          writes_base;
   int unsigned seed_val;

   dma_engine #(
      .FIFO_DEPTH    (4),
      .MAX_PKT_BYTES (MAX_PKT_BYTES)
   ) u_dma_engine (
      .clk            (clk),
      .reset          (reset),
      .rd_start       (rd_start),
      .rd_addr        (rd_addr),
      .rd_done        (rd_done),
      .rd_size_err    (rd_size_err),
      .rd_mac         (rd_mac),
      .rd_size        (rd_size),
      .rd_in_progress (rd_in_progress),
      .pkt_avail      (pkt_avail),
      .rd_request     (rd_request),
      .rd_request_q   (rd_request_q),
      .data_frm_cnet  (data_frm_cnet),
      .cnet_empty     (cnet_empty),
      .rd_en          (rd_en),
      .wb             (wb),
      .wb_ack         (wb_ack)
   );

   dma_pkt_source u_src (
      .clk           (clk),
      .reset         (reset),
      .rd_request    (rd_request),
      .rd_request_q  (rd_request_q),
      .rd_en         (rd_en),
      .pkt_avail     (pkt_avail),
      .data_frm_cnet (data_frm_cnet),
      .cnet_empty    (cnet_empty)
   );

   dma_host_mem u_mem (
      .clk    (clk),
      .reset  (reset),
      .wb     (wb),
      .wb_ack (wb_ack)
   );

   initial
      clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // ==============================
   // Checks and reference
   // ==============================
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
      begin
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, want);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Round-robin grant from the pointer, then the length rules
   function automatic expect_t predict_transfer(input logic [NUM_QUEUES-1:0] avail,
                                                input logic [NUM_QUEUES-1:0][31:0] head,
                                                input queue_idx_t ptr);
      expect_t    r;
      queue_idx_t q;
      logic       found;
      r     = '0;
      found = 1'b0;
      for (int i = 0; i < NUM_QUEUES; i++)
      begin
         q = queue_idx_t'((int'(ptr) + i) % NUM_QUEUES);
         if (!found && avail[q])
         begin
            found = 1'b1;
            r.q   = q;
         end
      end
      r.size   = head[r.q][15:0];
      r.err    = (r.size == 0) || (r.size > MAX_PKT_BYTES);
      r.nwords = r.err ? 11'd0 : 11'((r.size + 3) / 4);   // Last word written whole
      return r;
   endfunction

   function automatic int pick_length(input int q, input int p);
      int len;
      if (q == 1 && p == 1)
         len = 0;                                  // Empty packet
      else if (q == 3 && p == 2)
         len = MAX_PKT_BYTES + 1;                  // Just too large
      else if (q == 0 && p == 3)
         len = MAX_PKT_BYTES;                      // Largest legal
      else
         len = $urandom_range(120, 1);
      return len;
   endfunction

   // ==============================
   // Comparison process
   // ==============================
   always @(posedge clk)
   begin
      if (!reset && rd_request)
      begin
         check_value("rd_request", rd_request, busy);
         check_value("rd_request_q", rd_request_q, exp_cur.q);
      end
      if (!reset && (rd_done || rd_size_err))
      begin
         check_value("rd_done", rd_done, busy && !exp_cur.err);
         check_value("rd_size_err", rd_size_err, busy && exp_cur.err);
         if (exp_cur.err)
            check_value("rd_in_progress", rd_in_progress, 1'b0);
         else
         begin
            check_value("rd_mac", rd_mac, exp_cur.q);
            check_value("rd_size", rd_size, exp_cur.size);
            for (int i = 0; i < exp_cur.nwords; i++)
               check_value($sformatf("mem[%h]", rd_addr + 4 * i),
                           u_mem.peek(rd_addr + 4 * i),
                           src_word[exp_cur.q][exp_head][i + 1]);
         end
         check_value("bus write count", u_mem.n_writes - writes_base, exp_cur.nwords);
         ev_cnt++;
      end
   end

   // ==============================
   // Stimulus
   // ==============================
   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   task automatic check_idle_outputs;
      check_value("rd_request", rd_request, 1'b0);
      check_value("rd_en", rd_en, 1'b0);
      check_value("rd_done", rd_done, 1'b0);
      check_value("rd_size_err", rd_size_err, 1'b0);
      check_value("rd_in_progress", rd_in_progress, 1'b0);
      check_value("wb.cyc", wb.cyc, 1'b0);
      check_value("wb.stb", wb.stb, 1'b0);
   endtask

   task automatic load_packet(input int q, input int len);
      int         nw;
      data_word_t w;
      nw = 0;
      if (len > 0 && len <= MAX_PKT_BYTES)
         nw = (len + 3) / 4;                       // Bad lengths carry no payload
      w = {16'($urandom), 16'(len)};               // Upper half is not part of the size
      src_word[q][src_cnt[q]][0] = w;
      u_src.add_word(q, w);
      for (int i = 1; i <= nw; i++)
      begin
         w = $urandom;
         src_word[q][src_cnt[q]][i] = w;
         u_src.add_word(q, w);
      end
      u_src.close_packet(q, nw + 1);
      src_cnt[q]++;
   endtask

   task automatic run_transfer(input host_addr_t base);
      logic [NUM_QUEUES-1:0]       avail;
      logic [NUM_QUEUES-1:0][31:0] head;
      int                          target;
      for (int q = 0; q < NUM_QUEUES; q++)
      begin
         avail[q] = (src_head[q] < src_cnt[q]);
         head[q]  = avail[q] ? src_word[q][src_head[q]][0] : '0;
      end
      exp_cur     = predict_transfer(avail, head, ref_ptr);
      exp_head    = src_head[exp_cur.q];
      writes_base = u_mem.n_writes;
      target      = ev_cnt + 1;
      busy        = 1'b1;
      rd_addr     = base;
      rd_start    = 1'b1;
      next_cycle();
      rd_start = 1'b0;
      check_value("rd_in_progress", rd_in_progress, 1'b1);   // Reader left IDLE
      wait (ev_cnt == target);
      busy = 1'b0;
      src_head[exp_cur.q]++;
      ref_ptr = exp_cur.q + 1'b1;                  // Pointer steps past the grant
      next_cycle();
   endtask

   initial
   begin
      seed_val    = $urandom(SEED);
      reset       = 1'b1;
      rd_start    = 1'b0;
      rd_addr     = '0;
      busy        = 1'b0;
      ev_cnt      = 0;
      ref_ptr     = '0;
      exp_cur     = '0;
      exp_head    = 0;
      writes_base = 0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      check_idle_outputs();

      // Start with every queue empty, no request may follow
      rd_start = 1'b1;
      next_cycle();
      rd_start = 1'b0;
      repeat (10) next_cycle();
      check_idle_outputs();

      // Every queue busy, round-robin from queue 0 with two bad lengths among them
      for (int q = 0; q < NUM_QUEUES; q++)
         for (int p = 0; p < 4; p++)
            load_packet(q, pick_length(q, p));
      repeat (2) next_cycle();
      for (int n = 0; n < N_PKTS - 1; n++)
         run_transfer(32'h1000_0000 + 32'(n) * 32'h1000);

      // Single packet on queue 2, found past the empty queues 0 and 1
      load_packet(2, 13);
      repeat (2) next_cycle();
      run_transfer(32'h1000_0000 + 32'(N_PKTS - 1) * 32'h1000);

      check_value("transfers completed", ev_cnt, N_PKTS);
      check_value("pkt_avail", pkt_avail, '0);
      check_idle_outputs();
      $display("Test passed");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("Watchdog expired after %0d cycles, transfers did not finish", WATCHDOG_CYC);
      $display("Test failed");
      $fatal(1, "Timeout");
   end

endmodule

// ==== dma_engine.f ====
verilog/dma_pkg.sv
verilog/dma_rr_arb.sv
verilog/dma_cnet_reader.sv
verilog/dma_read_fifo.sv
verilog/dma_host_writer.sv
verilog/dma_engine.sv
bench/dma_bench_models.sv
bench/dma_engine_tb.sv

// ==== Bender.yml ====
package:
  name: dma_engine

sources:
  # RTL, package first
  - files:
      - verilog/dma_pkg.sv
      - verilog/dma_rr_arb.sv
      - verilog/dma_cnet_reader.sv
      - verilog/dma_read_fifo.sv
      - verilog/dma_host_writer.sv
      - verilog/dma_engine.sv
  # Bench models and testbench top
  - target: test
    files:
      - bench/dma_bench_models.sv
      - bench/dma_engine_tb.sv
